/* rtl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus widths and types
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [DATA_W/8-1:0] strb_t;
    typedef logic [1:0]          resp_t;
    typedef logic [7:0]          byte_t;
    typedef logic [63:0]         mtime_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address map
    localparam int APB_SLV_NUM = 3;
    localparam int SLV_UART    = 0;
    localparam int SLV_CLINT   = 1;
    localparam int SLV_PLIC    = 2;

    localparam addr_t UART_BASE  = 32'h1000_0000;
    localparam addr_t UART_MASK  = 32'h0000_0fff;  // 4 KiB
    localparam addr_t CLINT_BASE = 32'h0200_0000;
    localparam addr_t CLINT_MASK = 32'h0000_ffff;  // 64 KiB
    localparam addr_t PLIC_BASE  = 32'h0c00_0000;
    localparam addr_t PLIC_MASK  = 32'h003f_ffff;  // 4 MiB

    localparam addr_t UART_RBR_THR      = 32'h0;
    localparam addr_t UART_IER          = 32'h4;
    localparam addr_t UART_LSR          = 32'h8;
    localparam addr_t CLINT_MSIP        = 32'h0;
    localparam addr_t CLINT_MTIMECMP_LO = 32'h4000;
    localparam addr_t CLINT_MTIMECMP_HI = 32'h4004;
    localparam addr_t CLINT_MTIME_LO    = 32'hbff8;
    localparam addr_t CLINT_MTIME_HI    = 32'hbffc;
    localparam addr_t PLIC_PRIO         = 32'h0;  // one word per source id
    localparam addr_t PLIC_PENDING      = 32'h1000;
    localparam addr_t PLIC_ENABLE       = 32'h2000;
    localparam addr_t PLIC_THRESHOLD    = 32'h20_0000;
    localparam addr_t PLIC_CLAIM        = 32'h20_0004;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // interrupts and uart fifo
    localparam int IRQ_NUM  = 4;  // source ids 1..4
    localparam int IRQ_ID_W = $clog2(IRQ_NUM + 1);
    localparam int PRIO_W   = 3;

    typedef logic [IRQ_NUM-1:0]  irq_src_t;
    typedef logic [IRQ_ID_W-1:0] irq_id_t;
    typedef logic [PRIO_W-1:0]   prio_t;

    localparam int UART_FIFO_DEPTH = 4;
    localparam int UART_PTR_W      = $clog2(UART_FIFO_DEPTH);

    typedef logic [UART_PTR_W-1:0] fifo_ptr_t;
    typedef logic [UART_PTR_W:0]   fifo_cnt_t;

    localparam fifo_cnt_t UART_FIFO_FULL = fifo_cnt_t'(UART_FIFO_DEPTH);

endpackage

`default_nettype wire

/* rtl/axil_apb_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module axil_apb_bridge
    import soc_pkg::*;
(
    input  wire logic             clock,
    input  wire logic             rst_n_i,
    // axi4-lite slave
    input  wire logic             s_awvalid_i,
    output logic                  s_awready_o,
    input  wire addr_t            s_awaddr_i,
    input  wire logic             s_wvalid_i,
    output logic                  s_wready_o,
    input  wire data_t            s_wdata_i,
    input  wire strb_t            s_wstrb_i,
    output logic                  s_bvalid_o,
    input  wire logic             s_bready_i,
    output resp_t                 s_bresp_o,
    input  wire logic             s_arvalid_i,
    output logic                  s_arready_o,
    input  wire addr_t            s_araddr_i,
    output logic                  s_rvalid_o,
    input  wire logic             s_rready_i,
    output data_t                 s_rdata_o,
    output resp_t                 s_rresp_o,
    // apb master
    output logic [APB_SLV_NUM-1:0] psel_o,
    output logic                  penable_o,
    output logic                  pwrite_o,
    output addr_t                 paddr_o,
    output data_t                 pwdata_o,
    output strb_t                 pstrb_o,
    input  wire data_t            prdata_uart_i,
    input  wire data_t            prdata_clint_i,
    input  wire data_t            prdata_plic_i,
    input  wire logic             pslverr_uart_i,
    input  wire logic             pslverr_clint_i,
    input  wire logic             pslverr_plic_i
);
    typedef enum logic [2:0] {IDLE, SETUP, ACCESS, WRESP, RRESP} bridge_state_e;

    bridge_state_e          state_q;
    addr_t                  addr_q, dec_addr;
    data_t                  wdata_q, rdata_q, prdata_mux;
    strb_t                  strb_q;
    resp_t                  resp_q;
    logic                   write_q, wr_hs, rd_hs, pslverr_mux;
    logic [APB_SLV_NUM-1:0] sel_q, hit;

    // aw and w only accepted together and writes go before reads
    assign wr_hs       = (state_q == IDLE) && s_awvalid_i && s_wvalid_i;
    assign rd_hs       = (state_q == IDLE) && !wr_hs && s_arvalid_i;
    assign s_awready_o = wr_hs;
    assign s_wready_o  = wr_hs;
    assign s_arready_o = rd_hs;

    assign dec_addr        = wr_hs ? s_awaddr_i : s_araddr_i;
    assign hit[SLV_UART]   = (dec_addr & ~UART_MASK) == UART_BASE;
    assign hit[SLV_CLINT]  = (dec_addr & ~CLINT_MASK) == CLINT_BASE;
    assign hit[SLV_PLIC]   = (dec_addr & ~PLIC_MASK) == PLIC_BASE;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (wr_hs || rd_hs) begin
                        if (|hit) state_q <= SETUP;
                        else      state_q <= wr_hs ? WRESP : RRESP;  // unmapped so no apb access
                    end
                end
                SETUP:   state_q <= ACCESS;
                ACCESS:  state_q <= write_q ? WRESP : RRESP;
                WRESP:   if (s_bready_i) state_q <= IDLE;
                RRESP:   if (s_rready_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (wr_hs || rd_hs) begin
            addr_q  <= dec_addr;
            wdata_q <= s_wdata_i;
            strb_q  <= s_wstrb_i;
            write_q <= wr_hs;
            sel_q   <= hit;
            resp_q  <= RESP_SLVERR;  // kept only if nothing matched
            rdata_q <= '0;
        end
        if (state_q == ACCESS) begin
            resp_q  <= pslverr_mux ? RESP_SLVERR : RESP_OKAY;
            rdata_q <= write_q ? '0 : prdata_mux;
        end
    end

    always_comb begin
        prdata_mux  = '0;
        pslverr_mux = 1'b0;
        if (sel_q[SLV_UART]) begin
            prdata_mux  = prdata_uart_i;
            pslverr_mux = pslverr_uart_i;
        end
        if (sel_q[SLV_CLINT]) begin
            prdata_mux  = prdata_clint_i;
            pslverr_mux = pslverr_clint_i;
        end
        if (sel_q[SLV_PLIC]) begin
            prdata_mux  = prdata_plic_i;
            pslverr_mux = pslverr_plic_i;
        end
    end

    assign psel_o     = (state_q == SETUP || state_q == ACCESS) ? sel_q : '0;
    assign penable_o  = state_q == ACCESS;
    assign pwrite_o   = write_q;
    assign paddr_o    = addr_q;
    assign pwdata_o   = wdata_q;
    assign pstrb_o    = strb_q;
    assign s_bvalid_o = state_q == WRESP;
    assign s_rvalid_o = state_q == RRESP;
    assign s_bresp_o  = resp_q;
    assign s_rresp_o  = resp_q;
    assign s_rdata_o  = rdata_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_psel_onehot: assert property (@(posedge clock) disable iff (!rst_n_i)
        $onehot0(psel_o));
    // access phase follows a setup phase to the same slave
    a_penable_setup: assert property (@(posedge clock) disable iff (!rst_n_i)
        penable_o |-> psel_o != '0 && psel_o == $past(psel_o) && !$past(penable_o));
    a_resp_excl: assert property (@(posedge clock) disable iff (!rst_n_i)
        !(s_bvalid_o && s_rvalid_o));

endmodule

`default_nettype wire

/* rtl/apb_uart.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_uart
    import soc_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  rst_n_i,
    input  wire logic  psel_i,
    input  wire logic  penable_i,
    input  wire logic  pwrite_i,
    input  wire addr_t paddr_i,
    input  wire data_t pwdata_i,
    output data_t      prdata_o,
    output logic       pslverr_o,
    output logic       tx_valid_o,
    output byte_t      tx_data_o,
    input  wire logic  rx_valid_i,
    input  wire byte_t rx_data_i,
    output logic       irq_o
);
    byte_t     fifo_mem [UART_FIFO_DEPTH];
    fifo_ptr_t wr_ptr_q, rd_ptr_q;
    fifo_cnt_t count_q;
    logic      ier_q, overrun_q, data_rdy, fifo_full;
    logic      acc_wr, acc_rd, push, pop;
    addr_t     off;

    assign off       = paddr_i & UART_MASK;
    assign acc_wr    = psel_i && penable_i && pwrite_i;
    assign acc_rd    = psel_i && penable_i && !pwrite_i;
    assign data_rdy  = count_q != '0;
    assign fifo_full = count_q == UART_FIFO_FULL;
    assign push      = rx_valid_i && !fifo_full;
    assign pop       = acc_rd && off == UART_RBR_THR && data_rdy;
    assign irq_o     = ier_q && data_rdy;

    always_comb begin
        pslverr_o = 1'b0;
        case (off)
            UART_RBR_THR: prdata_o = data_rdy ? data_t'(fifo_mem[rd_ptr_q]) : '0;
            UART_IER:     prdata_o = data_t'(ier_q);
            UART_LSR:     prdata_o = data_t'({1'b1, 3'b000, overrun_q, data_rdy});  // thre, oe, dr
            default: begin
                prdata_o  = '0;
                pslverr_o = psel_i;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (push) fifo_mem[wr_ptr_q] <= rx_data_i;
        if (acc_wr && off == UART_RBR_THR) tx_data_o <= pwdata_i[7:0];
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            ier_q      <= 1'b0;
            overrun_q  <= 1'b0;
            tx_valid_o <= 1'b0;
        end else begin
            tx_valid_o <= acc_wr && off == UART_RBR_THR;
            if (acc_wr && off == UART_IER) ier_q <= pwdata_i[0];
            // pointers wrap on their own, depth is a power of two
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
            if (rx_valid_i && fifo_full)     overrun_q <= 1'b1;  // byte dropped
            else if (acc_rd && off == UART_LSR) overrun_q <= 1'b0;
        end
    end

    a_fifo_bound: assert property (@(posedge clock) disable iff (!rst_n_i)
        count_q <= UART_FIFO_FULL);

endmodule

`default_nettype wire

/* rtl/apb_clint.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_clint
    import soc_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  rst_n_i,
    input  wire logic  psel_i,
    input  wire logic  penable_i,
    input  wire logic  pwrite_i,
    input  wire addr_t paddr_i,
    input  wire data_t pwdata_i,
    input  wire strb_t pstrb_i,
    output data_t      prdata_o,
    output logic       pslverr_o,
    output logic       msip_o,
    output logic       mtip_o
);
    mtime_t mtime_q, mtime_nxt, mtimecmp_q;
    logic   msip_q, acc_wr;
    addr_t  off;

    function automatic data_t merge_strb(data_t old_w, data_t new_w, strb_t strb);
        data_t res;
        res = old_w;
        for (int b = 0; b < DATA_W / 8; b++) begin
            if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    assign off      = paddr_i & CLINT_MASK;
    assign acc_wr   = psel_i && penable_i && pwrite_i;
    assign msip_o   = msip_q;
    assign mtip_o   = mtime_q >= mtimecmp_q;

    // a written half replaces the increment for that half only
    always_comb begin
        mtime_nxt = mtime_q + 64'd1;
        if (acc_wr && off == CLINT_MTIME_LO)
            mtime_nxt[31:0] = merge_strb(mtime_q[31:0], pwdata_i, pstrb_i);
        if (acc_wr && off == CLINT_MTIME_HI)
            mtime_nxt[63:32] = merge_strb(mtime_q[63:32], pwdata_i, pstrb_i);
    end

    always_comb begin
        pslverr_o = 1'b0;
        case (off)
            CLINT_MSIP:        prdata_o = data_t'(msip_q);
            CLINT_MTIMECMP_LO: prdata_o = mtimecmp_q[31:0];
            CLINT_MTIMECMP_HI: prdata_o = mtimecmp_q[63:32];
            CLINT_MTIME_LO:    prdata_o = mtime_q[31:0];
            CLINT_MTIME_HI:    prdata_o = mtime_q[63:32];
            default: begin
                prdata_o  = '0;
                pslverr_o = psel_i;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            msip_q     <= 1'b0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;  // no timer irq until programmed
        end else begin
            mtime_q <= mtime_nxt;
            if (acc_wr && off == CLINT_MSIP && pstrb_i[0]) msip_q <= pwdata_i[0];
            if (acc_wr && off == CLINT_MTIMECMP_LO)
                mtimecmp_q[31:0] <= merge_strb(mtimecmp_q[31:0], pwdata_i, pstrb_i);
            if (acc_wr && off == CLINT_MTIMECMP_HI)
                mtimecmp_q[63:32] <= merge_strb(mtimecmp_q[63:32], pwdata_i, pstrb_i);
        end
    end

endmodule

`default_nettype wire

/* rtl/apb_plic.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_plic
    import soc_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     rst_n_i,
    input  wire logic     psel_i,
    input  wire logic     penable_i,
    input  wire logic     pwrite_i,
    input  wire addr_t    paddr_i,
    input  wire data_t    pwdata_i,
    input  wire strb_t    pstrb_i,
    output data_t         prdata_o,
    output logic          pslverr_o,
    input  wire irq_src_t src_i,
    output logic          meip_o
);
    prio_t    prio_q [IRQ_NUM];
    prio_t    threshold_q, best_prio;
    irq_src_t pending_q, enable_q, inflight_q;
    irq_src_t prio_hit, claim_oh, complete_oh;
    irq_id_t  claim_id;
    logic     acc_wr, claim_rd, complete_wr;
    addr_t    off;

    assign off         = paddr_i & PLIC_MASK;
    assign acc_wr      = psel_i && penable_i && pwrite_i;
    assign claim_rd    = psel_i && penable_i && !pwrite_i && off == PLIC_CLAIM;
    assign complete_wr = acc_wr && off == PLIC_CLAIM && pstrb_i[0];
    assign meip_o      = |claim_oh;

    // strict compare from the threshold so prio 0 never wins and ties keep the lower id
    always_comb begin
        best_prio = threshold_q;
        claim_oh  = '0;
        claim_id  = '0;
        for (int k = 0; k < IRQ_NUM; k++) begin
            prio_hit[k]    = off == PLIC_PRIO + addr_t'(4 * (k + 1));
            complete_oh[k] = complete_wr && pwdata_i[IRQ_ID_W-1:0] == irq_id_t'(k + 1);
            if (pending_q[k] && enable_q[k] && prio_q[k] > best_prio) begin
                best_prio   = prio_q[k];
                claim_oh    = '0;
                claim_oh[k] = 1'b1;
                claim_id    = irq_id_t'(k + 1);
            end
        end
    end

    always_comb begin
        prdata_o  = '0;
        pslverr_o = 1'b0;
        if (|prio_hit) begin
            for (int k = 0; k < IRQ_NUM; k++) begin
                if (prio_hit[k]) prdata_o = data_t'(prio_q[k]);
            end
        end else begin
            case (off)
                PLIC_PENDING:   prdata_o = data_t'({pending_q, 1'b0});  // bit n is id n
                PLIC_ENABLE:    prdata_o = data_t'({enable_q, 1'b0});
                PLIC_THRESHOLD: prdata_o = data_t'(threshold_q);
                PLIC_CLAIM:     prdata_o = data_t'(claim_id);
                default:        pslverr_o = psel_i;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            for (int k = 0; k < IRQ_NUM; k++) prio_q[k] <= '0;
            threshold_q <= '0;
            pending_q   <= '0;
            enable_q    <= '0;
            inflight_q  <= '0;
        end else begin
            // level sources pend again only once completed
            pending_q  <= (pending_q | (src_i & ~inflight_q)) & ~(claim_oh & {IRQ_NUM{claim_rd}});
            inflight_q <= (inflight_q | (claim_oh & {IRQ_NUM{claim_rd}})) & ~complete_oh;
            if (acc_wr && pstrb_i[0]) begin
                for (int k = 0; k < IRQ_NUM; k++) begin
                    if (prio_hit[k]) prio_q[k] <= pwdata_i[PRIO_W-1:0];
                end
                if (off == PLIC_ENABLE)    enable_q    <= pwdata_i[IRQ_NUM:1];
                if (off == PLIC_THRESHOLD) threshold_q <= pwdata_i[PRIO_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/periph_top.sv */
`timescale 1ns/10ps
`default_nettype none

module periph_top
    import soc_pkg::*;
(
    input  wire logic               clock,
    input  wire logic               rst_n_i,
    input  wire logic               s_awvalid_i,
    output logic                    s_awready_o,
    input  wire addr_t              s_awaddr_i,
    input  wire logic               s_wvalid_i,
    output logic                    s_wready_o,
    input  wire data_t              s_wdata_i,
    input  wire strb_t              s_wstrb_i,
    output logic                    s_bvalid_o,
    input  wire logic               s_bready_i,
    output resp_t                   s_bresp_o,
    input  wire logic               s_arvalid_i,
    output logic                    s_arready_o,
    input  wire addr_t              s_araddr_i,
    output logic                    s_rvalid_o,
    input  wire logic               s_rready_i,
    output data_t                   s_rdata_o,
    output resp_t                   s_rresp_o,
    output logic                    uart_tx_valid_o,
    output byte_t                   uart_tx_data_o,
    input  wire logic               uart_rx_valid_i,
    input  wire byte_t              uart_rx_data_i,
    input  wire logic [IRQ_NUM-2:0] ext_irq_i,  // plic sources 2..4
    output logic                    msip_o,
    output logic                    mtip_o,
    output logic                    meip_o
);
    logic [APB_SLV_NUM-1:0] psel;
    logic                   penable, pwrite, uart_irq;
    logic                   pslverr_uart, pslverr_clint, pslverr_plic;
    addr_t                  paddr;
    data_t                  pwdata, prdata_uart, prdata_clint, prdata_plic;
    strb_t                  pstrb;

    axil_apb_bridge i_bridge (
        .clock, .rst_n_i,
        .s_awvalid_i, .s_awready_o, .s_awaddr_i,
        .s_wvalid_i, .s_wready_o, .s_wdata_i, .s_wstrb_i,
        .s_bvalid_o, .s_bready_i, .s_bresp_o,
        .s_arvalid_i, .s_arready_o, .s_araddr_i,
        .s_rvalid_o, .s_rready_i, .s_rdata_o, .s_rresp_o,
        .psel_o(psel), .penable_o(penable), .pwrite_o(pwrite),
        .paddr_o(paddr), .pwdata_o(pwdata), .pstrb_o(pstrb),
        .prdata_uart_i(prdata_uart), .prdata_clint_i(prdata_clint),
        .prdata_plic_i(prdata_plic), .pslverr_uart_i(pslverr_uart),
        .pslverr_clint_i(pslverr_clint), .pslverr_plic_i(pslverr_plic)
    );

    apb_uart i_uart (
        .clock, .rst_n_i,
        .psel_i(psel[SLV_UART]), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata_uart), .pslverr_o(pslverr_uart),
        .tx_valid_o(uart_tx_valid_o), .tx_data_o(uart_tx_data_o),
        .rx_valid_i(uart_rx_valid_i), .rx_data_i(uart_rx_data_i),
        .irq_o(uart_irq)
    );

    apb_clint i_clint (
        .clock, .rst_n_i,
        .psel_i(psel[SLV_CLINT]), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .pstrb_i(pstrb),
        .prdata_o(prdata_clint), .pslverr_o(pslverr_clint),
        .msip_o, .mtip_o
    );

    apb_plic i_plic (
        .clock, .rst_n_i,
        .psel_i(psel[SLV_PLIC]), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .pstrb_i(pstrb),
        .prdata_o(prdata_plic), .pslverr_o(pslverr_plic),
        .src_i({ext_irq_i, uart_irq}),  // uart is source 1
        .meip_o
    );

endmodule

`default_nettype wire

/* sim/tb_periph_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_periph_top
    import soc_pkg::*;
();
    localparam int    WAIT_MAX  = 40;
    localparam int    MTIP_MAX  = 300;
    localparam [31:0] LFSR_SEED = 32'h6ec7ea12;
    localparam addr_t UNMAPPED  = 32'h3000_0000;

    logic               clock, rst_n_i;
    logic               s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o;
    addr_t              s_awaddr_i, s_araddr_i;
    data_t              s_wdata_i, s_rdata_o;
    strb_t              s_wstrb_i;
    logic               s_bvalid_o, s_bready_i, s_arvalid_i, s_arready_o;
    logic               s_rvalid_o, s_rready_i;
    resp_t              s_bresp_o, s_rresp_o;
    logic               uart_tx_valid_o, uart_rx_valid_i;
    byte_t              uart_tx_data_o, uart_rx_data_i;
    logic [IRQ_NUM-2:0] ext_irq_i;
    logic               msip_o, mtip_o, meip_o;

    logic [31:0] lfsr_q = LFSR_SEED;
    byte_t       tx_seen [$];
    byte_t       rx_bytes [6];
    data_t       rd_data, t0, t1;

    periph_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        assert (act_v === exp_v) else begin
            fail_run($sformatf("Mismatch at %0d ns: %s expected 0x%0h, actual 0x%0h",
                               $time, name, exp_v, act_v));
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic int lfsr_bits(input int nbits);
        int   val;
        logic fb;
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = (val << 1) | int'(fb);
        end
        return val;
    endfunction

    // mapped windows go through setup and access and the rest answer at once
    function automatic int expected_latency(input addr_t addr);
        if (addr >= UART_BASE && addr <= UART_BASE + UART_MASK)    return 3;
        if (addr >= CLINT_BASE && addr <= CLINT_BASE + CLINT_MASK) return 3;
        if (addr >= PLIC_BASE && addr <= PLIC_BASE + PLIC_MASK)    return 3;
        return 1;
    endfunction

    task automatic axil_write(input addr_t addr, input data_t data, input resp_t exp_resp);
        int cyc;
        int stall;
        s_awaddr_i  <= addr;
        s_wdata_i   <= data;
        s_wstrb_i   <= '1;
        s_awvalid_i <= 1'b1;
        s_wvalid_i  <= 1'b1;
        cyc = 0;
        do begin
            @(posedge clock);
            cyc++;
            if (cyc > WAIT_MAX) fail_run("Timeout waiting for the AW/W handshake");
        end while (!(s_awready_o && s_wready_o));
        s_awvalid_i <= 1'b0;
        s_wvalid_i  <= 1'b0;
        cyc = 0;
        do begin
            @(posedge clock);
            cyc++;
            if (cyc > WAIT_MAX) fail_run("Timeout waiting for the write response");
        end while (!s_bvalid_o);
        check_equal("s_bvalid_o latency", expected_latency(addr), cyc);
        stall = lfsr_bits(2);
        repeat (stall) @(posedge clock);  // back-pressure
        s_bready_i <= 1'b1;
        @(posedge clock);
        check_equal("s_bresp_o", exp_resp, s_bresp_o);
        s_bready_i <= 1'b0;
    endtask

    task automatic axil_read(input addr_t addr, input resp_t exp_resp, output data_t data);
        int cyc;
        int stall;
        s_araddr_i  <= addr;
        s_arvalid_i <= 1'b1;
        cyc = 0;
        do begin
            @(posedge clock);
            cyc++;
            if (cyc > WAIT_MAX) fail_run("Timeout waiting for the AR handshake");
        end while (!s_arready_o);
        s_arvalid_i <= 1'b0;
        cyc = 0;
        do begin
            @(posedge clock);
            cyc++;
            if (cyc > WAIT_MAX) fail_run("Timeout waiting for the read response");
        end while (!s_rvalid_o);
        check_equal("s_rvalid_o latency", expected_latency(addr), cyc);
        stall = lfsr_bits(2);
        repeat (stall) @(posedge clock);
        s_rready_i <= 1'b1;
        @(posedge clock);
        check_equal("s_rresp_o", exp_resp, s_rresp_o);
        data = s_rdata_o;
        s_rready_i <= 1'b0;
    endtask

    task automatic wait_meip(input logic level);
        int cyc;
        cyc = 0;
        while (meip_o !== level) begin
            cyc++;
            if (cyc > WAIT_MAX) fail_run($sformatf("meip_o never became %0b", level));
            @(posedge clock);
        end
    endtask

    task automatic wait_mtip();
        int cyc;
        cyc = 0;
        while (mtip_o !== 1'b1) begin
            cyc++;
            if (cyc > MTIP_MAX) fail_run("mtip_o never rose after mtimecmp was set");
            @(posedge clock);
        end
    endtask

    always @(posedge clock) begin
        if (rst_n_i && uart_tx_valid_o) tx_seen.push_back(uart_tx_data_o);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // protocol checks
    a_tx_single: assert property (@(posedge clock) disable iff (!rst_n_i)
        uart_tx_valid_o |=> !uart_tx_valid_o)
        else fail_run("uart_tx_valid_o stayed high for more than one cycle");
    a_b_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
        else fail_run("write response changed before it was accepted");
    a_r_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
        else fail_run("read response changed before it was accepted");
    a_no_accept: assert property (@(posedge clock) disable iff (!rst_n_i)
        s_bvalid_o || s_rvalid_o |-> !s_awready_o && !s_wready_o && !s_arready_o)
        else fail_run("bridge accepted an address while a response was pending");

    initial begin
        repeat (5000) @(posedge clock);
        fail_run("Simulation watchdog expired");
    end

    initial begin
        rst_n_i         = 1'b0;
        s_awvalid_i     = 1'b0;
        s_awaddr_i      = '0;
        s_wvalid_i      = 1'b0;
        s_wdata_i       = '0;
        s_wstrb_i       = '0;
        s_bready_i      = 1'b0;
        s_arvalid_i     = 1'b0;
        s_araddr_i      = '0;
        s_rready_i      = 1'b0;
        uart_rx_valid_i = 1'b0;
        uart_rx_data_i  = '0;
        ext_irq_i       = '0;
        repeat (3) @(posedge clock);
        rst_n_i <= 1'b1;
        @(posedge clock);
        check_equal("s_awready_o", 0, s_awready_o);
        check_equal("s_wready_o", 0, s_wready_o);
        check_equal("s_arready_o", 0, s_arready_o);
        check_equal("s_bvalid_o", 0, s_bvalid_o);
        check_equal("s_rvalid_o", 0, s_rvalid_o);
        check_equal("uart_tx_valid_o", 0, uart_tx_valid_o);
        check_equal("msip_o", 0, msip_o);
        check_equal("mtip_o", 0, mtip_o);
        check_equal("meip_o", 0, meip_o);

        // uart transmit
        axil_write(UART_BASE + UART_RBR_THR, 32'h41, RESP_OKAY);
        axil_write(UART_BASE + UART_RBR_THR, 32'h5a, RESP_OKAY);
        check_equal("uart_tx_valid_o pulses", 2, tx_seen.size());
        check_equal("uart_tx_data_o", 8'h41, tx_seen[0]);
        check_equal("uart_tx_data_o", 8'h5a, tx_seen[1]);

        // uart receive where the fifth byte overflows
        for (int i = 0; i < 5; i++) begin
            rx_bytes[i] = byte_t'(lfsr_bits(8));
            uart_rx_valid_i <= 1'b1;
            uart_rx_data_i  <= rx_bytes[i];
            @(posedge clock);
        end
        uart_rx_valid_i <= 1'b0;
        axil_read(UART_BASE + UART_LSR, RESP_OKAY, rd_data);
        check_equal("s_rdata_o (LSR)", 32'h23, rd_data);  // thre, oe, dr
        for (int i = 0; i < 4; i++) begin
            axil_read(UART_BASE + UART_RBR_THR, RESP_OKAY, rd_data);
            check_equal("s_rdata_o (RBR)", rx_bytes[i], rd_data);
        end
        axil_read(UART_BASE + UART_LSR, RESP_OKAY, rd_data);
        check_equal("s_rdata_o (LSR)", 32'h20, rd_data);

        // uart rx irq through plic source 1
        rx_bytes[5] = byte_t'(lfsr_bits(8));
        uart_rx_valid_i <= 1'b1;
        uart_rx_data_i  <= rx_bytes[5];
        @(posedge clock);
        uart_rx_valid_i <= 1'b0;
        axil_write(UART_BASE + UART_IER, 32'h1, RESP_OKAY);
        axil_write(PLIC_BASE + PLIC_ENABLE, 32'h2, RESP_OKAY);
        check_equal("meip_o", 0, meip_o);  // priority still 0
        axil_write(PLIC_BASE + PLIC_PRIO + 32'd4, 32'h1, RESP_OKAY);
        wait_meip(1'b1);
        axil_read(PLIC_BASE + PLIC_CLAIM, RESP_OKAY, rd_data);
        check_equal("s_rdata_o (claim)", 1, rd_data);
        check_equal("meip_o", 0, meip_o);
        axil_read(UART_BASE + UART_RBR_THR, RESP_OKAY, rd_data);
        check_equal("s_rdata_o (RBR)", rx_bytes[5], rd_data);
        axil_write(PLIC_BASE + PLIC_CLAIM, 32'd1, RESP_OKAY);

        // clint
        axil_write(CLINT_BASE + CLINT_MSIP, 32'h1, RESP_OKAY);
        check_equal("msip_o", 1, msip_o);
        axil_read(CLINT_BASE + CLINT_MTIME_LO, RESP_OKAY, t0);
        axil_write(CLINT_BASE + CLINT_MTIMECMP_LO, t0 + 32'd64, RESP_OKAY);
        axil_write(CLINT_BASE + CLINT_MTIMECMP_HI, 32'h0, RESP_OKAY);
        check_equal("mtip_o", 0, mtip_o);
        wait_mtip();
        axil_read(CLINT_BASE + CLINT_MTIME_LO, RESP_OKAY, t1);
        assert (t1 > t0) else fail_run("mtime did not advance between two reads");
        assert (t1 >= t0 + 32'd64) else fail_run("mtip_o rose before mtime reached mtimecmp");
        axil_write(CLINT_BASE + CLINT_MSIP, 32'h0, RESP_OKAY);
        check_equal("msip_o", 0, msip_o);

        // plic sources 2 and 4
        axil_write(PLIC_BASE + PLIC_PRIO + 32'd8, 32'd5, RESP_OKAY);
        axil_write(PLIC_BASE + PLIC_PRIO + 32'd16, 32'd3, RESP_OKAY);
        axil_write(PLIC_BASE + PLIC_THRESHOLD, 32'd1, RESP_OKAY);
        axil_write(PLIC_BASE + PLIC_ENABLE, 32'h14, RESP_OKAY);
        ext_irq_i <= 3'b101;
        wait_meip(1'b1);
        axil_read(PLIC_BASE + PLIC_CLAIM, RESP_OKAY, rd_data);
        check_equal("s_rdata_o (claim)", 2, rd_data);
        check_equal("meip_o", 1, meip_o);
        axil_read(PLIC_BASE + PLIC_CLAIM, RESP_OKAY, rd_data);
        check_equal("s_rdata_o (claim)", 4, rd_data);
        check_equal("meip_o", 0, meip_o);
        axil_read(PLIC_BASE + PLIC_CLAIM, RESP_OKAY, rd_data);
        check_equal("s_rdata_o (claim)", 0, rd_data);
        axil_write(PLIC_BASE + PLIC_CLAIM, 32'd2, RESP_OKAY);
        wait_meip(1'b1);  // source 2 still high
        axil_read(PLIC_BASE + PLIC_PENDING, RESP_OKAY, rd_data);
        check_equal("s_rdata_o (pending)", 32'h4, rd_data);
        ext_irq_i <= '0;
        axil_read(PLIC_BASE + PLIC_CLAIM, RESP_OKAY, rd_data);
        check_equal("s_rdata_o (claim)", 2, rd_data);
        axil_write(PLIC_BASE + PLIC_CLAIM, 32'd2, RESP_OKAY);
        axil_write(PLIC_BASE + PLIC_CLAIM, 32'd4, RESP_OKAY);
        check_equal("meip_o", 0, meip_o);

        // error responses
        axil_write(UNMAPPED, 32'h55, RESP_SLVERR);
        axil_read(UNMAPPED, RESP_SLVERR, rd_data);
        check_equal("s_rdata_o (unmapped)", 0, rd_data);
        axil_write(UART_BASE + 32'hc, 32'h66, RESP_SLVERR);
        axil_read(UART_BASE + 32'hc, RESP_SLVERR, rd_data);
        check_equal("uart_tx_valid_o pulses", 2, tx_seen.size());

        // a read offered with a write waits until the write response is taken
        s_araddr_i  <= UART_BASE + UART_LSR;
        s_arvalid_i <= 1'b1;
        axil_write(UART_BASE + UART_IER, 32'h0, RESP_OKAY);
        axil_read(UART_BASE + UART_LSR, RESP_OKAY, rd_data);
        check_equal("s_rdata_o (LSR)", 32'h20, rd_data);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
rtl/soc_pkg.sv
rtl/axil_apb_bridge.sv
rtl/apb_uart.sv
rtl/apb_clint.sv
rtl/apb_plic.sv
rtl/periph_top.sv
sim/tb_periph_top.sv

/* run.sh */
#!/bin/sh
# build and run the peripheral testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f build.f --top-module tb_periph_top \
    -o tb_periph_top || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_periph_top 2>&1)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
